/* list.f */
hw/te_pkg.sv
hw/te_itype_decode.sv
hw/te_retire_fsm.sv
hw/te_packet_out.sv
hw/te_ingress_top.sv
tests/te_tb_clk.sv
tests/te_ingress_checker.sv
tests/te_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the trace encoder ingress testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module te_tb -f list.f -o te_tb_sim

./obj_dir/te_tb_sim | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
  exit 0
fi
echo "run did not pass, see sim.log"
exit 1

/* tests/te_tb.sv */
// te_tb: directed and random tests, packet reference model, monitor and compare task
module te_tb import te_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  logic       clk;
  logic       rst_n;
  commit_t    commit;
  trap_t      trap;
  logic       pkt_valid;
  te_packet_t pkt;

  // expected packets in order from the model
  te_packet_t exp_q[$];
  te_packet_t exp_pkt;
  te_packet_t last_pkt;
  int         exp_total;
  int         rx_count;
  int         mismatch_count;
  int         other_count;
  integer     seed;

  // model state
  logic       m_idle;
  xaddr_t     m_iaddr;
  iretire_t   m_count;
  logic       m_last;
  priv_lvl_t  m_priv;
  seq_t       m_seq;

  te_tb_clk i_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  te_ingress_top dut0 (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .commit_i       (commit),
    .trap_i         (trap),
    .packet_valid_o (pkt_valid),
    .packet_o       (pkt)
  );

  task check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
      mismatch_count++;
    end
  endtask

  // packet rule applied one commit cycle at a time
  task model_step(input commit_t c, input trap_t t);
    te_packet_t p;
    logic       ends;
    logic       spec;
    iretire_t   sz;
    p    = '0;
    ends = 1'b0;
    spec = c.valid && (c.is_eret || c.is_branch || c.is_jalr);
    sz   = c.compressed ? iretire_t'(1) : iretire_t'(2);
    if (t.valid || spec) begin
      ends = 1'b1;
      if (t.valid) begin
        p.itype = t.interrupt ? INTERRUPT : EXCEPTION;
        p.cause = t.cause;
        p.tval  = t.interrupt ? '0 : t.tval;
      end else if (c.is_eret) begin
        p.itype = ERET;
      end else if (c.is_branch) begin
        p.itype = c.taken ? BR_TAKEN : BR_NOT_TAKEN;
      end else begin
        p.itype = JUMP_UNINFER;
      end
      if (c.valid) begin
        p.iaddr     = m_idle ? c.pc : m_iaddr;
        p.iretire   = m_count + sz;
        p.ilastsize = !c.compressed;
        p.priv      = c.priv;
      end else begin
        // held values when nothing retired
        p.iaddr     = m_iaddr;
        p.iretire   = m_count;
        p.ilastsize = m_last;
        p.priv      = m_priv;
      end
    end else if (c.valid) begin
      if (m_idle) begin
        m_iaddr = c.pc;
      end
      m_count = m_count + sz;
      m_idle  = 1'b0;
    end
    if (c.valid) begin
      m_last = !c.compressed;
      m_priv = c.priv;
    end
    if (ends) begin
      p.seq   = m_seq;
      m_seq   = m_seq + seq_t'(1);
      m_count = '0;
      m_idle  = 1'b1;
      exp_q.push_back(p);
      exp_total++;
    end
  endtask

  // one commit cycle with inputs changed 1 ns after the edge
  task drive_cycle(input commit_t c, input trap_t t);
    commit = c;
    trap   = t;
    model_step(c, t);
    @(posedge clk);
    #1;
    commit = '0;
    trap   = '0;
  endtask

  function automatic commit_t std_inst(input xaddr_t pc, input logic comp, input priv_lvl_t priv);
    commit_t c;
    c            = '0;
    c.valid      = 1'b1;
    c.pc         = pc;
    c.compressed = comp;
    c.priv       = priv;
    return c;
  endfunction

  // kind 0 taken, 1 not taken, 2 eret, 3 jalr
  function automatic commit_t end_inst(input xaddr_t pc, input logic comp, input int kind,
                                       input priv_lvl_t priv);
    commit_t c;
    c = std_inst(pc, comp, priv);
    case (kind)
      0: begin
        c.is_branch = 1'b1;
        c.taken     = 1'b1;
      end
      1: c.is_branch = 1'b1;
      2: c.is_eret = 1'b1;
      default: c.is_jalr = 1'b1;
    endcase
    return c;
  endfunction

  // run of standard instructions with alternating or random sizes
  task run_standard(input int n, input logic rnd, inout xaddr_t pc);
    int   i;
    int   r;
    logic comp;
    for (i = 0; i < n; i++) begin
      r    = $random(seed);
      comp = rnd ? r[0] : i[0];
      drive_cycle(std_inst(pc, comp, PRIV_LVL_M), '0);
      pc = pc + (comp ? 32'd2 : 32'd4);
    end
  endtask

  task wait_packets;
    int cycles;
    cycles = 0;
    while (rx_count != exp_total && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (rx_count != exp_total) begin
      $display("timeout at %0t: %0d packets expected, only %0d received",
               $time, exp_total, rx_count);
      other_count++;
      exp_q.delete();
      rx_count = exp_total;
    end
  endtask

  // outputs sampled mid-cycle where they are stable
  always @(negedge clk) begin
    if (rst_n && pkt_valid) begin
      if (exp_q.size() == 0) begin
        $display("unexpected packet at %0t with iaddr %0h", $time, pkt.iaddr);
        other_count++;
      end else begin
        exp_pkt = exp_q.pop_front();
        check_value(pkt.iaddr, exp_pkt.iaddr, "iaddr");
        check_value(32'(pkt.iretire), 32'(exp_pkt.iretire), "iretire");
        check_value(32'(pkt.ilastsize), 32'(exp_pkt.ilastsize), "ilastsize");
        check_value(32'(pkt.itype), 32'(exp_pkt.itype), "itype");
        check_value(32'(pkt.cause), 32'(exp_pkt.cause), "cause");
        check_value(pkt.tval, exp_pkt.tval, "tval");
        check_value(32'(pkt.priv), 32'(exp_pkt.priv), "priv");
        check_value(32'(pkt.seq), 32'(exp_pkt.seq), "seq");
        last_pkt = pkt;
        rx_count++;
      end
    end
  end

  task idle_after_reset;
    commit_t c;
    int      i;
    // invalid commits with junk fields stay silent
    for (i = 0; i < 5; i++) begin
      c           = end_inst(xaddr_t'(32'h0f00 + i * 4), 1'b0, 0, PRIV_LVL_M);
      c.valid     = 1'b0;
      drive_cycle(c, '0);
    end
    drive_cycle(end_inst(32'h1000, 1'b0, 0, PRIV_LVL_M), '0);
    wait_packets();
    check_value(32'(last_pkt.seq), 32'd0, "first packet seq");
  endtask

  task block_end_kinds;
    xaddr_t pc;
    int     k;
    for (k = 0; k < 4; k++) begin
      pc = xaddr_t'(32'h2000 + k * 256);
      run_standard(3, 1'b0, pc);
      drive_cycle(end_inst(pc, 1'b1, k, PRIV_LVL_S), '0);
      wait_packets();
    end
  endtask

  // two back to back branches that each open a block
  task branch_first_blocks;
    drive_cycle(end_inst(32'h3000, 1'b0, 0, PRIV_LVL_M), '0);
    drive_cycle(end_inst(32'h3100, 1'b1, 1, PRIV_LVL_M), '0);
    wait_packets();
  endtask

  // last standard is 32-bit so the held ilastsize is 1
  task exception_after_block;
    xaddr_t pc;
    trap_t  t;
    pc      = 32'h4000;
    run_standard(3, 1'b0, pc);
    t       = '0;
    t.valid = 1'b1;
    t.cause = 5'd13;
    t.tval  = 32'hdead_beef;
    drive_cycle('0, t);
    wait_packets();
  endtask

  // held ilastsize and priv differ from the retiring instruction
  task interrupt_with_retire;
    xaddr_t pc;
    trap_t  t;
    pc          = 32'h5000;
    run_standard(3, 1'b0, pc);
    t           = '0;
    t.valid     = 1'b1;
    t.interrupt = 1'b1;
    t.cause     = 5'd7;
    t.tval      = 32'h1234;
    drive_cycle(std_inst(pc, 1'b1, PRIV_LVL_S), t);
    wait_packets();
  endtask

  task random_blocks;
    xaddr_t    pc;
    trap_t     t;
    priv_lvl_t priv;
    int        i;
    int        r;
    int        kind;
    pc = 32'h8000_0000;
    for (i = 0; i < 300; i++) begin
      r    = $random(seed);
      kind = int'(r[5:3]) % 6;
      priv = (r[7:6] == 2'd0) ? PRIV_LVL_U : (r[7:6] == 2'd1) ? PRIV_LVL_S : PRIV_LVL_M;
      run_standard(int'(r[2:0]), 1'b1, pc);
      t           = '0;
      t.valid     = 1'b1;
      t.cause     = r[13:9];
      t.tval      = $random(seed);
      if (kind < 4) begin
        drive_cycle(end_inst(pc, r[8], kind, priv), '0);
      end else if (kind == 4) begin
        drive_cycle('0, t);
      end else begin
        t.interrupt = 1'b1;
        drive_cycle(std_inst(pc, r[8], priv), t);
      end
      pc = pc + 32'h40;
      wait_packets();
    end
  endtask

  initial begin
    int cycles;
    commit         = '0;
    trap           = '0;
    seed           = 32'he79027f8;
    exp_total      = 0;
    rx_count       = 0;
    mismatch_count = 0;
    other_count    = 0;
    last_pkt       = '0;
    m_idle         = 1'b1;
    m_iaddr        = '0;
    m_count        = '0;
    m_last         = 1'b0;
    m_priv         = PRIV_LVL_U;
    m_seq          = '0;
    cycles         = 0;
    while (!rst_n && cycles < 10) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      $display("reset was never released");
      other_count++;
    end
    @(posedge clk);
    #1;
    idle_after_reset();
    block_end_kinds();
    branch_first_blocks();
    exception_after_block();
    interrupt_with_retire();
    random_blocks();
    $display("errors: %0d value mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* tests/te_ingress_checker.sv */
// te_ingress_checker: bound assertions on packet timing, packet itype and tval gating
module te_ingress_checker import te_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input commit_t    commit_i,
  input trap_t      trap_i,
  input logic       packet_valid_i,
  input te_packet_t packet_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic block_end;

  // any trap, or a retiring eret, branch or jalr
  assign block_end = trap_i.valid ||
                     (commit_i.valid && (commit_i.is_eret || commit_i.is_branch ||
                                         commit_i.is_jalr));

  // a packet only follows a block end one cycle earlier
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    packet_valid_i |-> $past(block_end))
    else $error("packet without a block end in the previous cycle");

  // standard is never a packet type
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    packet_valid_i |-> (packet_i.itype != STANDARD))
    else $error("packet with itype STANDARD");

  // tval belongs to exceptions only
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (packet_valid_i && (packet_i.itype != EXCEPTION)) |-> (packet_i.tval == '0))
    else $error("nonzero tval on a non-exception packet");

endmodule

bind te_ingress_top te_ingress_checker i_checker (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .commit_i       (commit_i),
  .trap_i         (trap_i),
  .packet_valid_i (packet_valid_o),
  .packet_i       (packet_o)
);

/* tests/te_tb_clk.sv */
// te_tb_clk: 10 ns testbench clock and 2-cycle active-low reset
module te_tb_clk (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release just after the second rising edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

/* hw/te_ingress_top.sv */
// te_ingress_top: decoder, retire FSM and packet stage of the trace encoder ingress
module te_ingress_top import te_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  commit_t    commit_i,
  input  trap_t      trap_i,
  output logic       packet_valid_o,
  output te_packet_t packet_o
);

  uop_t       uop;
  cause_t     cause;
  xaddr_t     tval;
  logic       fire;
  te_packet_t fields;

  // combinational classification of the commit
  te_itype_decode i_decode (
    .commit_i (commit_i),
    .trap_i   (trap_i),
    .uop_o    (uop),
    .cause_o  (cause),
    .tval_o   (tval)
  );

  // block tracking, fire in the commit cycle
  te_retire_fsm i_fsm (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .uop_i    (uop),
    .cause_i  (cause),
    .tval_i   (tval),
    .fire_o   (fire),
    .fields_o (fields)
  );

  // registered packet one cycle later
  te_packet_out i_out (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fire_i         (fire),
    .fields_i       (fields),
    .packet_valid_o (packet_valid_o),
    .packet_o       (packet_o)
  );

endmodule

/* hw/te_packet_out.sv */
// te_packet_out: packet register, sequence counter and one-cycle valid pulse
module te_packet_out import te_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       fire_i,
  input  te_packet_t fields_i,
  output logic       packet_valid_o,
  output te_packet_t packet_o
);

  logic       valid_q;
  te_packet_t packet_q;
  seq_t       seq_q;

  // valid follows fire by one cycle, back to back allowed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fire_i;
    end
  end

  // capture fields and stamp the current sequence number
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      packet_q <= '0;
      seq_q    <= '0;
    end else if (fire_i) begin
      packet_q     <= fields_i;
      packet_q.seq <= seq_q;
      // wraps at 256
      seq_q        <= seq_q + seq_t'(1);
    end
  end

  assign packet_valid_o = valid_q;
  assign packet_o       = packet_q;

endmodule

/* hw/te_retire_fsm.sv */
// te_retire_fsm: block FSM, halfword counter and packet field formation
module te_retire_fsm import te_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  uop_t       uop_i,
  input  cause_t     cause_i,
  input  xaddr_t     tval_i,
  output logic       fire_o,
  output te_packet_t fields_o
);

  typedef enum logic {
    IDLE  = 1'b0,
    COUNT = 1'b1
  } state_e;

  state_e    state_q, state_d;
  xaddr_t    iaddr_q, iaddr_d;
  iretire_t  iretire_q, iretire_d;
  logic      ilastsize_q;
  priv_lvl_t priv_q;

  logic      is_trap;
  logic      is_special;
  logic      is_standard;
  iretire_t  inst_size;
  iretire_t  count_plus;
  xaddr_t    block_iaddr;

  // exception or interrupt, with or without a retiring instruction
  assign is_trap = (uop_i.itype == EXCEPTION) || (uop_i.itype == INTERRUPT);

  // eret, branches and jalr close the block they belong to
  assign is_special = uop_i.valid && !is_trap && (uop_i.itype != STANDARD);

  // plain instruction that extends the block
  assign is_standard = uop_i.valid && (uop_i.itype == STANDARD);

  // halfwords of the retiring instruction
  assign inst_size  = uop_i.compressed ? iretire_t'(1) : iretire_t'(2);
  assign count_plus = iretire_q + inst_size;

  // empty block starts at the incoming pc, otherwise at the stored one
  assign block_iaddr = (state_q == IDLE) ? uop_i.pc : iaddr_q;

  always_comb begin
    state_d   = state_q;
    iaddr_d   = iaddr_q;
    iretire_d = iretire_q;
    fire_o    = 1'b0;
    // seq is stamped downstream
    fields_o  = '0;

    if (is_trap) begin
      fire_o         = 1'b1;
      fields_o.itype = uop_i.itype;
      fields_o.cause = cause_i;
      // tval only reported for exceptions
      fields_o.tval  = (uop_i.itype == EXCEPTION) ? tval_i : '0;
      if (uop_i.valid) begin
        // instruction retired with the trap, count it
        fields_o.iaddr     = block_iaddr;
        fields_o.iretire   = count_plus;
        fields_o.ilastsize = !uop_i.compressed;
        fields_o.priv      = uop_i.priv;
      end else begin
        // nothing retired, report what is held
        fields_o.iaddr     = iaddr_q;
        fields_o.iretire   = iretire_q;
        fields_o.ilastsize = ilastsize_q;
        fields_o.priv      = priv_q;
      end
      iretire_d = '0;
      state_d   = IDLE;
    end else if (is_special) begin
      // block ends here, own size included
      fire_o             = 1'b1;
      fields_o.itype     = uop_i.itype;
      fields_o.iaddr     = block_iaddr;
      fields_o.iretire   = count_plus;
      fields_o.ilastsize = !uop_i.compressed;
      fields_o.priv      = uop_i.priv;
      iretire_d          = '0;
      state_d            = IDLE;
    end else if (is_standard) begin
      // first instruction of a block fixes iaddr
      if (state_q == IDLE) begin
        iaddr_d = uop_i.pc;
      end
      iretire_d = count_plus;
      state_d   = COUNT;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      iaddr_q   <= '0;
      iretire_q <= '0;
    end else begin
      state_q   <= state_d;
      iaddr_q   <= iaddr_d;
      iretire_q <= iretire_d;
    end
  end

  // last size and priv follow every retired instruction
  // a trap without retirement reports them later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ilastsize_q <= 1'b0;
      priv_q      <= PRIV_LVL_U;
    end else if (uop_i.valid) begin
      ilastsize_q <= !uop_i.compressed;
      priv_q      <= uop_i.priv;
    end
  end

endmodule

/* hw/te_itype_decode.sv */
// te_itype_decode: commit and trap classification into an itype uop, cause and tval split
module te_itype_decode import te_pkg::*; (
  input  commit_t commit_i,
  input  trap_t   trap_i,
  output uop_t    uop_o,
  output cause_t  cause_o,
  output xaddr_t  tval_o
);

  logic trap_exc;
  logic trap_int;
  logic inst_eret;
  logic inst_branch;
  logic inst_jalr;

  // trap side, interrupt flag picks between the two trap types
  assign trap_exc = trap_i.valid && !trap_i.interrupt;
  assign trap_int = trap_i.valid && trap_i.interrupt;

  // instruction side only counts when something retired
  assign inst_eret   = commit_i.valid && commit_i.is_eret;
  assign inst_branch = commit_i.valid && commit_i.is_branch;
  assign inst_jalr   = commit_i.valid && commit_i.is_jalr;

  always_comb begin
    // commit payload passes straight through
    uop_o.valid      = commit_i.valid;
    uop_o.pc         = commit_i.pc;
    uop_o.compressed = commit_i.compressed;
    uop_o.priv       = commit_i.priv;

    // first match wins, traps ahead of any instruction kind
    if (trap_exc) begin
      uop_o.itype = EXCEPTION;
    end else if (trap_int) begin
      uop_o.itype = INTERRUPT;
    end else if (inst_eret) begin
      uop_o.itype = ERET;
    end else if (inst_branch) begin
      // direction from the resolved branch
      uop_o.itype = commit_i.taken ? BR_TAKEN : BR_NOT_TAKEN;
    end else if (inst_jalr) begin
      // target not inferable from the binary
      uop_o.itype = JUMP_UNINFER;
    end else begin
      uop_o.itype = STANDARD;
    end
  end

  // cause code without the interrupt bit
  assign cause_o = trap_i.valid ? trap_i.cause : '0;

  // tval only meaningful alongside a trap
  assign tval_o = trap_i.valid ? trap_i.tval : '0;

endmodule

/* hw/te_pkg.sv */
// te_pkg: trace encoder widths, width typedefs, itype enum, commit/trap/uop/packet structs
package te_pkg;

  // address and trap value width
  localparam int unsigned XLEN        = 32;
  // trap cause code width
  localparam int unsigned CAUSE_LEN   = 5;
  // retired halfword count width
  localparam int unsigned IRETIRE_LEN = 16;
  // packet sequence number width
  localparam int unsigned SEQ_LEN     = 8;

  typedef logic [XLEN-1:0]        xaddr_t;
  typedef logic [CAUSE_LEN-1:0]   cause_t;
  typedef logic [IRETIRE_LEN-1:0] iretire_t;
  typedef logic [SEQ_LEN-1:0]     seq_t;

  // riscv privilege encoding, 2 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_t;

  // instruction type as carried in the packet
  typedef enum logic [2:0] {
    STANDARD     = 3'd0,
    EXCEPTION    = 3'd1,
    INTERRUPT    = 3'd2,
    ERET         = 3'd3,
    BR_NOT_TAKEN = 3'd4,
    BR_TAKEN     = 3'd5,
    JUMP_UNINFER = 3'd6
  } itype_e;

  // single retire port from the core
  typedef struct packed {
    logic      valid;
    xaddr_t    pc;
    logic      compressed;
    priv_lvl_t priv;
    logic      is_eret;
    logic      is_branch;
    logic      taken;
    logic      is_jalr;
  } commit_t;

  // trap port, may come with or without a retiring instruction
  typedef struct packed {
    logic   valid;
    logic   interrupt;
    cause_t cause;
    xaddr_t tval;
  } trap_t;

  // decoded commit
  typedef struct packed {
    logic      valid;
    itype_e    itype;
    xaddr_t    pc;
    logic      compressed;
    priv_lvl_t priv;
  } uop_t;

  // one packet per finished block
  typedef struct packed {
    xaddr_t    iaddr;
    iretire_t  iretire;
    logic      ilastsize;
    itype_e    itype;
    cause_t    cause;
    xaddr_t    tval;
    priv_lvl_t priv;
    seq_t      seq;
  } te_packet_t;

endpackage
